// ==== rtl/ipod_pkg.sv ====
package ipod_pkg;

  // ==============================
  // Widths with a meaning
  // ==============================
  typedef logic [15:0] sample_t;
  typedef logic [31:0] word_t;
  typedef logic [22:0] flash_addr_t;
  typedef logic [15:0] div_count_t;
  typedef logic [7:0]  ascii_t;
  // Active low, bit 0 is segment a
  typedef logic [6:0]  seg_t;

  // Six board digits, leftmost first
  typedef struct packed {
    seg_t hex5;
    seg_t hex4;
    seg_t hex3;
    seg_t hex2;
    seg_t hex1;
    seg_t hex0;
  } hex_digits_t;

  // Wishbone classic master request
  typedef struct packed {
    logic        cyc;
    logic        stb;
    flash_addr_t adr;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic playing;
    logic forward;
  } play_state_t;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT
  } fetch_state_e;

  // ==============================
  // Sample rate and speed steps
  // ==============================
  // About 22.05 kHz from 50 MHz
  localparam div_count_t DEFAULT_DIV_COUNT = 16'd2268;
  localparam div_count_t SPEED_STEP        = 16'd64;
  localparam div_count_t DIV_MIN           = 16'd256;
  localparam div_count_t DIV_MAX           = 16'd8192;

  // Push button positions in key_n
  localparam int KEY_UP   = 0;
  localparam int KEY_DOWN = 1;
  localparam int KEY_DFLT = 2;

  // Last word of the song in flash
  localparam flash_addr_t LAST_WORD_ADDR = 23'h7FFFF;

  // ==============================
  // Keyboard commands, upper case
  // ==============================
  localparam ascii_t CMD_PLAY       = 8'h45;
  localparam ascii_t CMD_PAUSE      = 8'h44;
  localparam ascii_t CMD_FWD        = 8'h46;
  localparam ascii_t CMD_BACK       = 8'h42;
  localparam ascii_t CMD_RESTART    = 8'h52;
  localparam ascii_t ASCII_CASE_BIT = 8'h20;

  // Hex digit patterns 0 to F, segments g..a
  localparam seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

// ==== rtl/speed_control.sv ====
`timescale 1ns/1ps

module speed_control (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  logic [2:0]           key_n,
  output ipod_pkg::div_count_t div_count
);
  import ipod_pkg::*;

  // Two flop synchronizer per button
  logic [2:0] key_meta;
  logic [2:0] key_sync;
  // Previous synchronized level for edge detection
  logic [2:0] key_prev;
  // One cycle press pulses
  logic [2:0] press;

  // ==============================
  // Button synchronizers
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // Buttons idle high
      key_meta <= '1;
      key_sync <= '1;
      key_prev <= '1;
      press    <= '0;
    end
    else
    begin
      key_meta <= key_n;
      key_sync <= key_meta;
      key_prev <= key_sync;
      // Falling edge of the synchronized level
      press    <= ~key_sync & key_prev;
    end
  end

  // ==============================
  // Divider count register
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      div_count <= DEFAULT_DIV_COUNT;
    else if (press[KEY_DFLT])
      div_count <= DEFAULT_DIV_COUNT;
    else if (press[KEY_UP])
    begin
      // Faster means a shorter period, floor at DIV_MIN
      if (div_count <= DIV_MIN + SPEED_STEP)
        div_count <= DIV_MIN;
      else
        div_count <= div_count - SPEED_STEP;
    end
    else if (press[KEY_DOWN])
    begin
      // Slower, ceiling at DIV_MAX
      if (div_count >= DIV_MAX - SPEED_STEP)
        div_count <= DIV_MAX;
      else
        div_count <= div_count + SPEED_STEP;
    end
  end

  // Tick generator never sees an out of range period
  a_div_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (div_count >= DIV_MIN) && (div_count <= DIV_MAX))
  else $error("speed_control: div_count %0d out of range", div_count);

endmodule

// ==== rtl/sample_tick_gen.sv ====
`timescale 1ns/1ps

module sample_tick_gen (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  ipod_pkg::div_count_t div_count,
  output logic                 tick
);
  import ipod_pkg::*;

  // Cycles left until the next tick
  div_count_t count;

  // Period of div_count cycles
  // New count only picked up at reload
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= DEFAULT_DIV_COUNT - 1'b1;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      // Reload and fire
      count <= div_count - 1'b1;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

// ==== rtl/playback_ctrl.sv ====
`timescale 1ns/1ps

module playback_ctrl (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  ipod_pkg::ascii_t      ascii_code,
  input  logic                  ascii_valid,
  output ipod_pkg::play_state_t play,
  output logic                  restart
);
  import ipod_pkg::*;

  // Command folded to upper case
  ascii_t cmd;

  // Clearing the case bit maps a..z onto A..Z
  assign cmd = ascii_code & ~ASCII_CASE_BIT;

  // ==============================
  // Command decoder
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // Paused, forward
      play.playing <= 1'b0;
      play.forward <= 1'b1;
      restart      <= 1'b0;
    end
    else
    begin
      // Restart is a single cycle pulse
      restart <= 1'b0;
      if (ascii_valid)
      begin
        case (cmd)
          CMD_PLAY:
            play.playing <= 1'b1;
          CMD_PAUSE:
            play.playing <= 1'b0;
          CMD_FWD:
            play.forward <= 1'b1;
          CMD_BACK:
            play.forward <= 1'b0;
          // Pointer jump handled by sample_fetch
          CMD_RESTART:
            restart <= 1'b1;
          // Any other key leaves state alone
          default:
            ;
        endcase
      end
    end
  end

endmodule

// ==== rtl/sample_fetch.sv ====
`timescale 1ns/1ps

module sample_fetch (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  logic                  tick,
  input  ipod_pkg::play_state_t play,
  input  logic                  restart,
  input  logic                  wb_ack,
  input  ipod_pkg::word_t       wb_dat,
  output ipod_pkg::wb_req_t     wb_req,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_valid
);
  import ipod_pkg::*;

  fetch_state_e state;
  // Word pointer and its successor in the play direction
  flash_addr_t  ptr;
  flash_addr_t  ptr_next;
  // Pointer after a possible restart this cycle
  flash_addr_t  ptr_base;
  // Set once the first half of the word has played
  logic         second;
  logic         fwd_q;
  logic         dir_chg;
  logic         sec_eff;
  // Open cycle outdated by a restart
  logic         stale;
  logic         start;
  logic         take;
  logic         play_hi;

  // A direction change starts the current word over
  assign dir_chg  = play.forward != fwd_q;
  assign sec_eff  = second & ~dir_chg;
  // Forward plays low then high, backward high then low
  assign play_hi  = play.forward ? sec_eff : ~sec_eff;
  assign ptr_base = restart ? (play.forward ? '0 : LAST_WORD_ADDR) : ptr;
  assign start    = (state == FETCH_IDLE) && tick && play.playing;
  assign take     = (state == FETCH_WAIT) && wb_ack && !stale && !restart;

  // Wrap at both ends of the song
  always_comb
  begin
    if (play.forward)
      ptr_next = (ptr == LAST_WORD_ADDR) ? '0 : ptr + 1'b1;
    else
      ptr_next = (ptr == '0) ? LAST_WORD_ADDR : ptr - 1'b1;
  end

  // ==============================
  // Wishbone classic read FSM
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= FETCH_IDLE;
      wb_req       <= '{cyc: 1'b0, stb: 1'b0, adr: '0, sel: 4'hF};
      stale        <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= take;
      case (state)
        FETCH_IDLE:
          if (start)
          begin
            // cyc and stb rise together, full word
            wb_req <= '{cyc: 1'b1, stb: 1'b1, adr: ptr_base, sel: 4'hF};
            stale  <= 1'b0;
            state  <= FETCH_WAIT;
          end
        FETCH_WAIT:
          if (wb_ack)
          begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            state      <= FETCH_IDLE;
          end
          else if (restart)
            stale <= 1'b1;
        default:
          state <= FETCH_IDLE;
      endcase
    end
  end

  // Selected half of the acked word
  always_ff @(posedge CLK_50M)
  begin
    if (take)
      audio_sample <= play_hi ? wb_dat[31:16] : wb_dat[15:0];
  end

  // ==============================
  // Pointer and half select
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ptr    <= '0;
      second <= 1'b0;
      fwd_q  <= 1'b1;
    end
    else
    begin
      fwd_q <= play.forward;
      if (restart)
      begin
        ptr    <= ptr_base;
        second <= 1'b0;
      end
      else if (take)
      begin
        // Step to the next word after both halves
        if (sec_eff)
          ptr <= ptr_next;
        second <= ~sec_eff;
      end
      else if (dir_chg)
        second <= 1'b0;
    end
  end

  // Request held steady while the slave stalls
  a_adr_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (wb_req.stb && !wb_ack) |=> (wb_req.stb && $stable(wb_req.adr)))
  else $error("sample_fetch: adr or stb changed before ack");

  // Flash too slow for the sample rate
  a_no_tick_drop: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    tick |-> !wb_req.cyc)
  else $error("sample_fetch: tick dropped, read still open");

endmodule

// ==== rtl/hex_display.sv ====
`timescale 1ns/1ps

module hex_display (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  ipod_pkg::div_count_t  div_count,
  output ipod_pkg::hex_digits_t hex
);
  import ipod_pkg::*;

  // Index 5 is the leftmost digit
  logic [5:0][3:0] nibble;
  seg_t [5:0]      seg;

  // Upper two digits always show zero
  assign nibble = {8'h00, div_count};

  // ==============================
  // Nibble to segment lookup
  // ==============================
  always_comb
  begin
    for (int i = 0; i < 6; i++)
    begin
      seg[i] = SEG_TABLE[nibble[i]];
    end
  end

  // Registered digits
  // Digit order of seg matches hex5 down to hex0
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      // All segments dark
      hex <= '1;
    else
      hex <= seg;
  end

endmodule

// ==== rtl/simple_ipod.sv ====
`timescale 1ns/1ps

module simple_ipod (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  logic [2:0]            key_n,
  input  ipod_pkg::ascii_t      ascii_code,
  input  logic                  ascii_valid,
  input  logic                  wb_ack,
  input  ipod_pkg::word_t       wb_dat,
  output ipod_pkg::wb_req_t     wb_req,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_valid,
  output ipod_pkg::hex_digits_t hex
);
  import ipod_pkg::*;

  // Sample period in CLK_50M cycles
  div_count_t  div_count;
  logic        tick;
  play_state_t play;
  logic        restart;

  // ==============================
  // Sample rate path
  // ==============================
  speed_control speed_control_i (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .key_n     (key_n),
    .div_count (div_count)
  );

  sample_tick_gen sample_tick_gen_i (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .div_count (div_count),
    .tick      (tick)
  );

  // Speed readout
  hex_display hex_display_i (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .div_count (div_count),
    .hex       (hex)
  );

  // ==============================
  // Keyboard control and flash
  // ==============================
  playback_ctrl playback_ctrl_i (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .ascii_code  (ascii_code),
    .ascii_valid (ascii_valid),
    .play        (play),
    .restart     (restart)
  );

  // Wishbone master toward the flash
  sample_fetch sample_fetch_i (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .tick         (tick),
    .play         (play),
    .restart      (restart),
    .wb_ack       (wb_ack),
    .wb_dat       (wb_dat),
    .wb_req       (wb_req),
    .audio_sample (audio_sample),
    .sample_valid (sample_valid)
  );

endmodule

// ==== tb/flash_model.sv ====
`timescale 1ns/1ps

module flash_model (
  input  logic              CLK_50M,
  input  logic              arst_n,
  input  ipod_pkg::wb_req_t wb_req,
  output logic              wb_ack,
  output ipod_pkg::word_t   wb_dat
);
  import ipod_pkg::*;

  // Wait state generator
  logic [31:0] rng;
  logic [31:0] rng_next;
  // Request accepted, counting down wait states
  logic        busy;
  logic [2:0]  wait_left;
  logic        req;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  assign rng_next = xorshift32(rng);
  // New strobe, not yet answered
  assign req = wb_req.cyc && wb_req.stb && !wb_ack;

  // ==============================
  // Wishbone classic slave
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rng       <= 32'd39;
      busy      <= 1'b0;
      wait_left <= 3'd0;
      wb_ack    <= 1'b0;
      wb_dat    <= '0;
    end
    else
    begin
      wb_ack <= 1'b0;
      if (req && !busy)
      begin
        rng <= rng_next;
        // High half scrambled, low half is the address
        wb_dat <= {wb_req.adr[15:0] ^ 16'hA5A5, wb_req.adr[15:0]};
        // 0 to 7 wait states
        if (rng_next[2:0] == 3'd0)
          wb_ack <= 1'b1;
        else
        begin
          busy      <= 1'b1;
          wait_left <= rng_next[2:0] - 3'd1;
        end
      end
      else if (busy)
      begin
        if (wait_left == 3'd0)
        begin
          wb_ack <= 1'b1;
          busy   <= 1'b0;
        end
        else
          wait_left <= wait_left - 3'd1;
      end
    end
  end

endmodule

// ==== tb/tb_simple_ipod.sv ====
`timescale 1ns/1ps

module tb_simple_ipod;
  import ipod_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DELAY = 2;
  // Longest gap between two samples with margin
  localparam int SAMPLE_WAIT = 3 * DEFAULT_DIV_COUNT;
  // About 80 sample periods against roughly 35 needed
  localparam int MAX_CYCLES  = 200000;

  logic        CLK_50M;
  logic        arst_n;
  logic [2:0]  key_n;
  ascii_t      ascii_code;
  logic        ascii_valid;
  logic        wb_ack;
  word_t       wb_dat;
  wb_req_t     wb_req;
  sample_t     audio_sample;
  logic        sample_valid;
  hex_digits_t hex;

  int          cycles = 0;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_err_start;
  string       cur_test;
  logic [31:0] rng_state;
  // Samples seen on the DUT output in arrival order
  sample_t     got_q[$];
  // Word address of the read behind each queued sample
  flash_addr_t adr_q[$];
  flash_addr_t acked_adr;

  // Reference player state
  flash_addr_t ref_ptr;
  logic        ref_second;
  logic        ref_fwd;
  logic        ref_playing;

  simple_ipod simple_ipod_i (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .key_n        (key_n),
    .ascii_code   (ascii_code),
    .ascii_valid  (ascii_valid),
    .wb_ack       (wb_ack),
    .wb_dat       (wb_dat),
    .wb_req       (wb_req),
    .audio_sample (audio_sample),
    .sample_valid (sample_valid),
    .hex          (hex)
  );

  flash_model flash_model_i (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .wb_req  (wb_req),
    .wb_ack  (wb_ack),
    .wb_dat  (wb_dat)
  );

  always #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;

  // Run limit
  always @(posedge CLK_50M)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles in test %s", cycles, cur_test);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Collect samples mid cycle where outputs are settled
  // The sample follows its ack by one cycle
  always @(negedge CLK_50M)
  begin
    if (arst_n && sample_valid)
    begin
      got_q.push_back(audio_sample);
      adr_q.push_back(acked_adr);
    end
    if (arst_n && wb_req.cyc && wb_ack)
    begin
      acked_adr = wb_req.adr;
      if (wb_req.sel !== 4'hF)
      begin
        errors++;
        $display("%s: read with byte select %h instead of a full word", cur_test, wb_req.sel);
      end
    end
  end

  // ==============================
  // Flash contents and reference
  // ==============================
  function automatic sample_t lo_half(input flash_addr_t addr);
    return addr[15:0];
  endfunction

  function automatic sample_t hi_half(input flash_addr_t addr);
    return addr[15:0] ^ 16'hA5A5;
  endfunction

  // Forward plays low first and backward high first
  function automatic sample_t ref_expected();
    logic hi;
    hi = ref_fwd ? ref_second : !ref_second;
    return hi ? hi_half(ref_ptr) : lo_half(ref_ptr);
  endfunction

  function automatic void ref_advance();
    if (ref_second)
    begin
      if (ref_fwd)
        ref_ptr = (ref_ptr == LAST_WORD_ADDR) ? '0 : ref_ptr + 23'd1;
      else
        ref_ptr = (ref_ptr == '0) ? LAST_WORD_ADDR : ref_ptr - 23'd1;
    end
    ref_second = !ref_second;
  endfunction

  function automatic void apply_cmd(input ascii_t code);
    ascii_t upper;
    upper = code & ~ASCII_CASE_BIT;
    case (upper)
      CMD_PLAY:
        ref_playing = 1'b1;
      CMD_PAUSE:
        ref_playing = 1'b0;
      CMD_FWD:
      begin
        // New direction restarts the word
        if (!ref_fwd)
          ref_second = 1'b0;
        ref_fwd = 1'b1;
      end
      CMD_BACK:
      begin
        if (ref_fwd)
          ref_second = 1'b0;
        ref_fwd = 1'b0;
      end
      CMD_RESTART:
      begin
        ref_ptr    = ref_fwd ? '0 : LAST_WORD_ADDR;
        ref_second = 1'b0;
      end
      default:
        ;
    endcase
  endfunction

  function automatic hex_digits_t hex_for(input div_count_t c);
    hex_digits_t h;
    h.hex5 = SEG_TABLE[0];
    h.hex4 = SEG_TABLE[0];
    h.hex3 = SEG_TABLE[c[15:12]];
    h.hex2 = SEG_TABLE[c[11:8]];
    h.hex1 = SEG_TABLE[c[7:4]];
    h.hex0 = SEG_TABLE[c[3:0]];
    return h;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ==============================
  // Drive and check helpers
  // ==============================
  // Every step ends just after a rising edge
  task automatic step();
    @(posedge CLK_50M);
    #DRIVE_DELAY;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic report_mismatch(input string what, input logic [47:0] exp,
                                 input logic [47:0] act);
    errors++;
    $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == test_err_start)
      $display("Test %s done, no errors", cur_test);
    else
    begin
      tests_failed++;
      $display("Test %s done, %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  // Pop one delivered sample and its read address, then step the reference
  task automatic compare_next(input string what, input sample_t exp);
    sample_t     act;
    flash_addr_t act_adr;
    act     = got_q.pop_front();
    act_adr = adr_q.pop_front();
    if (act !== exp)
      report_mismatch(what, exp, act);
    if (act_adr !== ref_ptr)
      report_mismatch({what, " address"}, ref_ptr, act_adr);
    ref_advance();
  endtask

  // Compare everything still queued with the reference
  task automatic drain_samples();
    while (got_q.size() > 0)
      compare_next("queued sample", ref_expected());
  endtask

  task automatic expect_sample(input string what, input sample_t exp);
    int waited;
    waited = 0;
    while (got_q.size() == 0 && waited < SAMPLE_WAIT)
    begin
      step();
      waited++;
    end
    if (got_q.size() == 0)
    begin
      errors++;
      $display("%s: no sample arrived for %s within %0d cycles", cur_test, what, waited);
    end
    else
      compare_next(what, exp);
  endtask

  // Sent once the bus is idle and earlier samples are checked
  task automatic send_cmd(input ascii_t code);
    int waited;
    waited = 0;
    while ((wb_req.cyc || sample_valid) && waited < 100)
    begin
      step();
      waited++;
    end
    if (wb_req.cyc || sample_valid)
    begin
      errors++;
      $display("%s: Wishbone read never closed before a command", cur_test);
    end
    drain_samples();
    apply_cmd(code);
    ascii_code  = code;
    ascii_valid = 1'b1;
    step();
    ascii_valid = 1'b0;
  endtask

  task automatic press_key(input int idx);
    key_n[idx] = 1'b0;
    wait_cycles(5);
    key_n[idx] = 1'b1;
    wait_cycles(10);
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_reset();
    int busy_cycles;
    begin_test("reset");
    busy_cycles = 0;
    repeat (3000)
    begin
      if (wb_req.cyc || wb_req.stb || sample_valid)
        busy_cycles++;
      step();
    end
    if (busy_cycles != 0)
    begin
      errors++;
      $display("%s: bus or sample_valid active in %0d idle cycles", cur_test, busy_cycles);
    end
    if (hex !== hex_for(DEFAULT_DIV_COUNT))
      report_mismatch("hex", hex_for(DEFAULT_DIV_COUNT), hex);
    end_test();
  endtask

  task automatic test_forward_play();
    begin_test("forward_play");
    send_cmd("e");
    for (int w = 0; w < 3; w++)
    begin
      expect_sample("low half", lo_half(flash_addr_t'(w)));
      expect_sample("high half", hi_half(flash_addr_t'(w)));
    end
    end_test();
  endtask

  task automatic test_pause_resume();
    begin_test("pause_resume");
    send_cmd("D");
    // An open read may still deliver one sample
    wait_cycles(20);
    if (got_q.size() > 1)
    begin
      errors++;
      $display("%s: %0d samples after pause", cur_test, got_q.size());
    end
    drain_samples();
    wait_cycles(3 * DEFAULT_DIV_COUNT);
    if (got_q.size() != 0)
    begin
      errors++;
      $display("%s: sample_valid seen while paused", cur_test);
    end
    send_cmd("E");
    expect_sample("resumed sample", ref_expected());
    end_test();
  endtask

  task automatic test_backward_wrap();
    begin_test("backward_wrap");
    send_cmd("B");
    send_cmd("R");
    expect_sample("last word high", hi_half(LAST_WORD_ADDR));
    expect_sample("last word low", lo_half(LAST_WORD_ADDR));
    expect_sample("wrapped word high", hi_half(LAST_WORD_ADDR - 23'd1));
    send_cmd("F");
    send_cmd("R");
    expect_sample("word 0 low", lo_half('0));
    end_test();
  endtask

  task automatic test_speed_control();
    begin_test("speed_control");
    press_key(KEY_UP);
    press_key(KEY_UP);
    press_key(KEY_DOWN);
    if (hex !== hex_for(DEFAULT_DIV_COUNT - SPEED_STEP))
      report_mismatch("hex after steps", hex_for(DEFAULT_DIV_COUNT - SPEED_STEP), hex);
    press_key(KEY_DFLT);
    if (hex !== hex_for(DEFAULT_DIV_COUNT))
      report_mismatch("hex after default", hex_for(DEFAULT_DIV_COUNT), hex);
    end_test();
  endtask

  task automatic test_random_commands();
    ascii_t      letters [5] = '{CMD_PLAY, CMD_PAUSE, CMD_FWD, CMD_BACK, CMD_RESTART};
    logic [31:0] r;
    int          idx;
    ascii_t      code;
    begin_test("random_commands");
    for (int n = 0; n < 12; n++)
    begin
      rng_state = xorshift32(rng_state);
      r         = rng_state;
      idx       = int'(r % 32'd5);
      code      = letters[idx];
      // Mixed case
      if (r[8])
        code = code | ASCII_CASE_BIT;
      send_cmd(code);
      if (ref_playing)
      begin
        expect_sample("random stream", ref_expected());
        expect_sample("random stream", ref_expected());
      end
      else
        wait_cycles(100);
    end
    drain_samples();
    end_test();
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial
  begin
    CLK_50M      = 1'b0;
    arst_n       = 1'b0;
    key_n        = 3'b111;
    ascii_code   = '0;
    ascii_valid  = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "startup";
    rng_state    = 32'd39;
    ref_ptr      = '0;
    ref_second   = 1'b0;
    ref_fwd      = 1'b1;
    ref_playing  = 1'b0;
    acked_adr    = '0;
    repeat (2) @(posedge CLK_50M);
    #DRIVE_DELAY;
    arst_n = 1'b1;
    test_reset();
    test_forward_play();
    test_pause_resume();
    test_backward_wrap();
    test_speed_control();
    test_random_commands();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== simple_ipod.f ====
rtl/ipod_pkg.sv
rtl/speed_control.sv
rtl/sample_tick_gen.sv
rtl/playback_ctrl.sv
rtl/sample_fetch.sv
rtl/hex_display.sv
rtl/simple_ipod.sv
tb/flash_model.sv
tb/tb_simple_ipod.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the simple_ipod testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_simple_ipod -f simple_ipod.f --Mdir obj_dir

status=0
./obj_dir/Vtb_simple_ipod > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
  echo "Run failed"
  exit 1
fi
echo "Run passed"
